/* common/clock_set_pkg.sv */
`default_nettype none

package clock_set_pkg;

    typedef logic [3:0]  bcd_digit_t;
    typedef logic [2:0]  weekday_t;    // 1 = monday, 7 = sunday, 0 = not computed
    typedef logic [83:0] display_word_t;
    typedef logic [21:0] hold_cnt_t;

    typedef struct packed {
        bcd_digit_t year_th;
        bcd_digit_t year_h;
        bcd_digit_t year_t;
        bcd_digit_t year_u;
        bcd_digit_t month_t;
        bcd_digit_t month_u;
        bcd_digit_t day_t;
        bcd_digit_t day_u;
        bcd_digit_t hour_t;
        bcd_digit_t hour_u;
        bcd_digit_t min_t;
        bcd_digit_t min_u;
        bcd_digit_t sec_t;
        bcd_digit_t sec_u;
    } date_time_t;

    // plus means left on the nav pair and up on the edit pair
    typedef struct packed {
        logic plus;
        logic minus;
    } btn_pair_t;

    typedef enum logic [3:0] {
        CUR_YEAR_TH,
        CUR_YEAR_H,
        CUR_YEAR_T,
        CUR_YEAR_U,
        CUR_MONTH_T,
        CUR_MONTH_U,
        CUR_DAY_T,
        CUR_DAY_U,
        CUR_HOUR_T,
        CUR_HOUR_U,
        CUR_MIN_T,
        CUR_MIN_U,
        CUR_SEC_T,
        CUR_SEC_U
    } cursor_t;

    localparam int         HOLD_CYCLES    = 2_500_000;
    localparam bcd_digit_t SEP_NIBBLE     = 4'hB;
    localparam weekday_t   WEEKDAY_SUNDAY = 3'd7;

    localparam date_time_t RESET_DATE = '{
        year_th: 4'd2, year_h: 4'd0, year_t: 4'd2, year_u: 4'd3,
        month_t: 4'd0, month_u: 4'd1,
        day_t:   4'd0, day_u:   4'd1,
        hour_t:  4'd0, hour_u:  4'd0,
        min_t:   4'd0, min_u:   4'd0,
        sec_t:   4'd0, sec_u:   4'd0
    };

endpackage

`default_nettype wire

/* hw/press_qualifier.sv */
`default_nettype none

module press_qualifier #(
    parameter int hold_len = clock_set_pkg::HOLD_CYCLES
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     enable,
    input  clock_set_pkg::btn_pair_t btn,
    output clock_set_pkg::btn_pair_t step
);
    import clock_set_pkg::*;

    hold_cnt_t hold_cnt;
    logic      held;
    logic      at_hold;

    assign held    = enable && (btn.plus || btn.minus);
    assign at_hold = held && (hold_cnt == hold_cnt_t'(hold_len));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
        end else if (!held) begin
            hold_cnt <= '0;                        // release restarts the count
        end else if (hold_cnt <= hold_cnt_t'(hold_len)) begin
            hold_cnt <= hold_cnt + 1'b1;           // parks one past hold_len
        end
    end

    assign step.plus  = at_hold && btn.plus;
    assign step.minus = at_hold && !btn.plus;     // plus wins

    a_step_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(step.plus && step.minus));

    // a held button yields a single pulse
    a_step_single: assert property (@(posedge clk) disable iff (!rst_n)
        (step.plus || step.minus) |=> !(step.plus || step.minus));

endmodule

`default_nettype wire

/* hw/cursor_ctrl.sv */
`default_nettype none

module cursor_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  clock_set_pkg::btn_pair_t nav_step,
    output clock_set_pkg::cursor_t   cursor
);
    import clock_set_pkg::*;

    cursor_t next_cursor;

    always_comb begin
        next_cursor = cursor;
        if (nav_step.plus) begin
            // left, toward year thousands
            if (cursor == CUR_YEAR_TH) begin
                next_cursor = CUR_SEC_U;
            end else begin
                next_cursor = cursor_t'(cursor - 4'd1);
            end
        end else if (nav_step.minus) begin
            if (cursor == CUR_SEC_U) begin
                next_cursor = CUR_YEAR_TH;
            end else begin
                next_cursor = cursor_t'(cursor + 4'd1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor <= CUR_YEAR_TH;
        end else begin
            cursor <= next_cursor;
        end
    end

endmodule

`default_nettype wire

/* editor/calendar_clamp.sv */
`default_nettype none

module calendar_clamp (
    input  clock_set_pkg::date_time_t raw,
    output clock_set_pkg::date_time_t legal
);
    import clock_set_pkg::*;

    logic [7:0] month;
    logic [7:0] day;
    logic [7:0] month_len;
    logic       leap;

    // two bcd digits form a multiple of 4 when 2*tens + units is
    function automatic logic bcd_mult4(input bcd_digit_t tens, input bcd_digit_t units);
        logic [4:0] s;
        s = {tens, 1'b0} + {1'b0, units};
        return s[1:0] == 2'b00;
    endfunction

    always_comb begin
        legal = raw;

        if ({raw.year_th, raw.year_h, raw.year_t, raw.year_u} == 16'h0000) begin
            legal.year_u = 4'd1;
        end

        month = {raw.month_t, raw.month_u};
        if (month == 8'h00) begin
            month = 8'h01;
        end else if (month > 8'h12) begin
            month = 8'h12;
        end
        {legal.month_t, legal.month_u} = month;

        if ({raw.hour_t, raw.hour_u} > 8'h23) begin
            {legal.hour_t, legal.hour_u} = 8'h23;
        end

        if ({legal.year_t, legal.year_u} == 8'h00) begin
            leap = bcd_mult4(legal.year_th, legal.year_h);   // century rule
        end else begin
            leap = bcd_mult4(legal.year_t, legal.year_u);
        end

        case (month)
            8'h01, 8'h03, 8'h05, 8'h07, 8'h08, 8'h10, 8'h12: month_len = 8'h31;
            8'h02:   month_len = leap ? 8'h29 : 8'h28;
            default: month_len = 8'h30;
        endcase

        day = {raw.day_t, raw.day_u};
        if (day == 8'h00) begin
            day = 8'h01;
        end else if (day > month_len) begin
            day = month_len;
        end
        {legal.day_t, legal.day_u} = day;
    end

endmodule

`default_nettype wire

/* editor/digit_editor.sv */
`default_nettype none

module digit_editor (
    input  logic                      clk,
    input  logic                      rst_n,
    input  clock_set_pkg::btn_pair_t  edit_step,
    input  clock_set_pkg::cursor_t    cursor,
    output clock_set_pkg::date_time_t date_time
);
    import clock_set_pkg::*;

    bcd_digit_t [13:0] cur_digits;     // index 13 is year thousands
    bcd_digit_t [13:0] new_digits;
    bcd_digit_t        sel_digit;
    bcd_digit_t        digit_max;
    bcd_digit_t        next_digit;
    logic [3:0]        sel_idx;
    date_time_t        stepped;
    date_time_t        legal;

    // fixed wrap limit of each position
    always_comb begin
        case (cursor)
            CUR_MONTH_T: digit_max = 4'd1;
            CUR_DAY_T:   digit_max = 4'd3;
            CUR_HOUR_T:  digit_max = 4'd2;
            CUR_MIN_T:   digit_max = 4'd5;
            CUR_SEC_T:   digit_max = 4'd5;
            default:     digit_max = 4'd9;
        endcase
    end

    always_comb begin
        cur_digits = date_time;
        sel_idx    = 4'd13 - cursor;
        sel_digit  = cur_digits[sel_idx];
        next_digit = sel_digit;
        if (edit_step.plus) begin
            next_digit = (sel_digit >= digit_max) ? 4'd0 : sel_digit + 4'd1;
        end else if (edit_step.minus) begin
            next_digit = (sel_digit == 4'd0) ? digit_max : sel_digit - 4'd1;
        end
        new_digits          = cur_digits;
        new_digits[sel_idx] = next_digit;
        stepped             = new_digits;
    end

    calendar_clamp u_clamp (
        .raw   (stepped),
        .legal (legal)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            date_time <= RESET_DATE;
        end else if (edit_step.plus || edit_step.minus) begin
            date_time <= legal;
        end
    end

    // stored date stays legal across every step
    a_date_legal: assert property (@(posedge clk) disable iff (!rst_n)
        ({date_time.month_t, date_time.month_u} inside {[8'h01:8'h12]}) &&
        ({date_time.day_t, date_time.day_u} != 8'h00));

endmodule

`default_nettype wire

/* weekday/weekday_calc.sv */
`default_nettype none

module weekday_calc (
    input  logic                      clk,
    input  logic                      rst_n,
    input  clock_set_pkg::date_time_t date_time,
    output clock_set_pkg::weekday_t   weekday
);
    import clock_set_pkg::*;

    logic [13:0] year_bin;     // up to 9999
    logic [3:0]  month_bin;
    logic [4:0]  day_bin;
    logic [13:0] s1_year;
    logic [3:0]  s1_month;     // 3..14
    logic [4:0]  s1_day;
    logic        s1_valid;
    logic [15:0] yr;
    logic [15:0] mon;
    logic [15:0] sum;
    weekday_t    rem;

    always_comb begin
        year_bin  = 14'(date_time.year_th) * 14'd1000 + 14'(date_time.year_h) * 14'd100
                  + 14'(date_time.year_t) * 14'd10 + 14'(date_time.year_u);
        month_bin = date_time.month_t * 4'd10 + date_time.month_u;
        day_bin   = 5'(date_time.day_t) * 5'd10 + 5'(date_time.day_u);
    end

    // stage 1 maps jan and feb to months 13 and 14 of the year before
    always_ff @(posedge clk) begin
        if (month_bin <= 4'd2) begin
            s1_month <= month_bin + 4'd12;
            s1_year  <= year_bin - 14'd1;
        end else begin
            s1_month <= month_bin;
            s1_year  <= year_bin;
        end
        s1_day <= day_bin;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= 1'b1;
        end
    end

    always_comb begin
        yr  = 16'(s1_year);
        mon = 16'(s1_month);
        sum = 16'(s1_day) + 16'd2 * mon + (16'd3 * (mon + 16'd1)) / 16'd5
            + yr + yr / 16'd4 - yr / 16'd100 + yr / 16'd400 + 16'd1;
        rem = weekday_t'(sum % 16'd7);
    end

    // stage 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weekday <= '0;
        end else if (s1_valid) begin
            weekday <= (rem == '0) ? WEEKDAY_SUNDAY : rem;
        end
    end

    a_weekday_range: assert property (@(posedge clk) disable iff (!rst_n)
        s1_valid |=> (weekday inside {[3'd1:3'd7]}));

endmodule

`default_nettype wire

/* hw/time_setter_top.sv */
`default_nettype none

module time_setter_top #(
    parameter int hold_len = clock_set_pkg::HOLD_CYCLES
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         set_mode,
    input  clock_set_pkg::btn_pair_t     nav_btn,
    input  clock_set_pkg::btn_pair_t     edit_btn,
    output clock_set_pkg::date_time_t    date_time,
    output clock_set_pkg::weekday_t      weekday,
    output clock_set_pkg::display_word_t display_word
);
    import clock_set_pkg::*;

    btn_pair_t nav_step;
    btn_pair_t edit_step;
    cursor_t   cursor;

    press_qualifier #(.hold_len(hold_len)) u_nav_qual (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (set_mode),
        .btn    (nav_btn),
        .step   (nav_step)
    );

    press_qualifier #(.hold_len(hold_len)) u_edit_qual (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (set_mode),
        .btn    (edit_btn),
        .step   (edit_step)
    );

    cursor_ctrl u_cursor (
        .clk      (clk),
        .rst_n    (rst_n),
        .nav_step (nav_step),
        .cursor   (cursor)
    );

    digit_editor u_editor (
        .clk       (clk),
        .rst_n     (rst_n),
        .edit_step (edit_step),
        .cursor    (cursor),
        .date_time (date_time)
    );

    weekday_calc u_weekday (
        .clk       (clk),
        .rst_n     (rst_n),
        .date_time (date_time),
        .weekday   (weekday)
    );

    // year, month, day, weekday, hour, minute, second
    assign display_word = {
        date_time.year_th, date_time.year_h, date_time.year_t, date_time.year_u, SEP_NIBBLE,
        date_time.month_t, date_time.month_u, SEP_NIBBLE,
        date_time.day_t, date_time.day_u, SEP_NIBBLE,
        {1'b0, weekday}, SEP_NIBBLE,
        date_time.hour_t, date_time.hour_u, SEP_NIBBLE,
        date_time.min_t, date_time.min_u, SEP_NIBBLE,
        date_time.sec_t, date_time.sec_u
    };

endmodule

`default_nettype wire

/* verification/tb_time_setter.sv */
`default_nettype none

module tb_time_setter;
    import clock_set_pkg::*;

    localparam int HOLD_LEN         = 4;
    localparam int DIRECTED_PRESSES = 100;
    localparam int RANDOM_PRESSES   = 200;
    localparam int TIMEOUT_CYCLES   = (DIRECTED_PRESSES + RANDOM_PRESSES) * 20 + 100;

    logic          clk;
    logic          rst_n;
    logic          set_mode;
    btn_pair_t     nav_btn;
    btn_pair_t     edit_btn;
    date_time_t    date_time;
    weekday_t      weekday;
    display_word_t display_word;

    int    m_d[14];              // model digits from year thousands down
    int    m_cur;                // model cursor position
    int    err_count;
    int    seed;
    int    r;
    bit    cmp_pending;
    string cur_test;

    time_setter_top #(.hold_len(HOLD_LEN)) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .set_mode     (set_mode),
        .nav_btn      (nav_btn),
        .edit_btn     (edit_btn),
        .date_time    (date_time),
        .weekday      (weekday),
        .display_word (display_word)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int ref_weekday(input int y, input int m, input int d);
        int s;
        if (m <= 2) begin
            m = m + 12;          // jan and feb belong to the year before
            y = y - 1;
        end
        s = d + 2 * m + (3 * (m + 1)) / 5 + y + y / 4 - y / 100 + y / 400 + 1;
        return (s % 7 == 0) ? 7 : s % 7;
    endfunction

    function automatic date_time_t model_date();
        logic [55:0] v;
        for (int i = 0; i < 14; i++)
            v[55 - 4 * i -: 4] = 4'(m_d[i]);
        return v;
    endfunction

    function automatic display_word_t expected_display(input date_time_t d, input int wd);
        return {d.year_th, d.year_h, d.year_t, d.year_u, 4'hB, d.month_t, d.month_u, 4'hB,
                d.day_t, d.day_u, 4'hB, 4'(wd), 4'hB, d.hour_t, d.hour_u, 4'hB,
                d.min_t, d.min_u, 4'hB, d.sec_t, d.sec_u};
    endfunction

    task automatic clamp_ref_date();
        int  year;
        int  month;
        int  day;
        int  mlen;
        bit  leap;
        year = m_d[0] * 1000 + m_d[1] * 100 + m_d[2] * 10 + m_d[3];
        if (year == 0) begin
            m_d[3] = 1;
            year   = 1;
        end
        month = m_d[4] * 10 + m_d[5];
        if (month == 0) month = 1;
        else if (month > 12) month = 12;
        m_d[4] = month / 10;
        m_d[5] = month % 10;
        if (m_d[8] * 10 + m_d[9] > 23) begin
            m_d[8] = 2;
            m_d[9] = 3;
        end
        if (year % 100 == 0) leap = ((year / 100) % 4 == 0);
        else leap = (year % 4 == 0);
        case (month)
            1, 3, 5, 7, 8, 10, 12: mlen = 31;
            2:       mlen = leap ? 29 : 28;
            default: mlen = 30;
        endcase
        day = m_d[6] * 10 + m_d[7];
        if (day == 0) day = 1;
        else if (day > mlen) day = mlen;
        m_d[6] = day / 10;
        m_d[7] = day % 10;
    endtask

    task automatic step_ref_digit(input bit plus);
        int dmax;
        case (m_cur)
            4:       dmax = 1;   // month tens
            6:       dmax = 3;
            8:       dmax = 2;
            10, 12:  dmax = 5;
            default: dmax = 9;
        endcase
        if (plus) m_d[m_cur] = (m_d[m_cur] >= dmax) ? 0 : m_d[m_cur] + 1;
        else m_d[m_cur] = (m_d[m_cur] == 0) ? dmax : m_d[m_cur] - 1;
        clamp_ref_date();
    endtask

    task automatic check_date(input string name, input date_time_t exp, input date_time_t act);
        if (act !== exp) begin
            err_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "date_time differs from model");
        end
    endtask

    task automatic check_weekday(input string name, input weekday_t exp, input weekday_t act);
        if (act !== exp) begin
            err_count++;
            $display("mismatch %s: expected %0d actual %0d", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "weekday differs from model");
        end
    endtask

    task automatic check_display(input string name, input display_word_t exp,
                                 input display_word_t act);
        if (act !== exp) begin
            err_count++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "display word differs from model");
        end
    endtask

    // hold, release, update the model, then hand over to the comparing process
    task automatic press(input bit nav, input bit plus);
        btn_pair_t b;
        b.plus  = plus;
        b.minus = !plus;
        @(posedge clk);
        #1;
        if (nav) nav_btn = b;
        else edit_btn = b;
        repeat (HOLD_LEN + 4) @(posedge clk);
        #1;
        nav_btn  = '0;
        edit_btn = '0;
        repeat (3) @(posedge clk);
        if (set_mode && nav) m_cur = plus ? (m_cur + 13) % 14 : (m_cur + 1) % 14;
        else if (set_mode) step_ref_digit(plus);
        cmp_pending = 1'b1;
        wait (!cmp_pending);
    endtask

    task automatic edit_times(input bit plus, input int n);
        repeat (n) press(1'b0, plus);
    endtask

    // shortest way round the 14 positions
    task automatic move_to(input int target);
        while (m_cur != target) begin
            if ((target - m_cur + 14) % 14 <= 7) press(1'b1, 1'b0);
            else press(1'b1, 1'b1);
        end
    endtask

    initial begin : compare_proc
        date_time_t exp_date;
        int         wd;
        forever begin
            wait (cmp_pending);
            repeat (2) @(posedge clk);
            @(negedge clk);
            exp_date = model_date();
            wd = ref_weekday(m_d[0] * 1000 + m_d[1] * 100 + m_d[2] * 10 + m_d[3],
                             m_d[4] * 10 + m_d[5], m_d[6] * 10 + m_d[7]);
            check_date(cur_test, exp_date, date_time);
            check_weekday(cur_test, weekday_t'(wd), weekday);
            check_display(cur_test, expected_display(exp_date, wd), display_word);
            cmp_pending = 1'b0;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n       = 1'b0;
        set_mode    = 1'b1;
        nav_btn     = '0;
        edit_btn    = '0;
        err_count   = 0;
        seed        = 11;
        cmp_pending = 1'b0;
        m_cur       = 0;
        m_d         = '{2, 0, 2, 3, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0};
        cur_test    = "reset";
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_date(cur_test, model_date(), date_time);
        check_weekday(cur_test, 3'd0, weekday);      // pipeline not filled yet
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_weekday(cur_test, 3'd7, weekday);
        check_display(cur_test, expected_display(model_date(), 7), display_word);

        cur_test = "cursor_wrap";
        press(1'b1, 1'b0);
        edit_times(1'b1, 1);                          // 2123
        edit_times(1'b0, 1);
        press(1'b1, 1'b1);
        press(1'b1, 1'b1);                            // wraps to seconds units
        edit_times(1'b1, 1);

        cur_test = "hour_tens_wrap";
        move_to(9);
        edit_times(1'b1, 5);
        move_to(8);
        edit_times(1'b0, 1);                          // 25 clamps to 23

        cur_test = "min_tens_wrap";
        move_to(10);
        edit_times(1'b0, 1);
        edit_times(1'b1, 1);

        cur_test = "april_31";
        move_to(5);
        edit_times(1'b1, 3);
        move_to(6);
        edit_times(1'b1, 3);
        move_to(7);
        edit_times(1'b1, 1);

        cur_test = "leap_2024";
        move_to(5);
        edit_times(1'b0, 2);
        move_to(3);
        edit_times(1'b1, 1);
        move_to(7);
        edit_times(1'b1, 1);
        move_to(3);
        edit_times(1'b0, 1);                          // back to 2023 with feb 28

        cur_test = "century_1900";
        move_to(0);
        edit_times(1'b0, 1);
        move_to(1);
        edit_times(1'b0, 1);
        move_to(2);
        edit_times(1'b0, 2);
        move_to(3);
        edit_times(1'b0, 3);
        move_to(7);
        edit_times(1'b1, 1);

        cur_test = "century_2000";
        move_to(0);
        edit_times(1'b1, 1);
        move_to(1);
        edit_times(1'b1, 1);
        move_to(7);
        edit_times(1'b1, 1);

        cur_test = "year_zero";
        move_to(0);
        edit_times(1'b0, 2);

        cur_test = "set_mode_low";
        @(posedge clk);
        #1;
        set_mode = 1'b0;
        press(1'b1, 1'b0);
        press(1'b0, 1'b1);
        @(posedge clk);
        #1;
        set_mode = 1'b1;
        edit_times(1'b1, 1);                          // still on year thousands

        cur_test = "random";
        repeat (RANDOM_PRESSES) begin
            r = $random(seed);
            press(r[0], r[1]);
        end

        if (err_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

/* files.f */
common/clock_set_pkg.sv
hw/press_qualifier.sv
hw/cursor_ctrl.sv
editor/calendar_clamp.sv
editor/digit_editor.sv
weekday/weekday_calc.sv
hw/time_setter_top.sv
verification/tb_time_setter.sv

/* Makefile */
TOP = tb_time_setter

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
